// File: ccu_pkg.sv
`default_nettype none

package ccu_pkg;

    localparam int unsigned NUM_SNOOPERS = 4;           // Snooping caches
    localparam int unsigned CD_DATA_W    = 64;          // Data beat width
    localparam int unsigned CD_MIN_BEATS = 1;           // Shortest data burst
    localparam int unsigned CD_MAX_BEATS = 8;           // Longest data burst

    // Index of a single snooper
    typedef logic [$clog2(NUM_SNOOPERS)-1:0] snoop_idx_t;

    // One bit per snooper
    typedef logic [NUM_SNOOPERS-1:0] snoop_mask_t;

    // Must hold 0 up to NUM_SNOOPERS
    typedef logic [$clog2(NUM_SNOOPERS+1)-1:0] drain_cnt_t;

    // Snoop control response, all flags merge by OR
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic error;
        logic data_transfer;
    } cr_chan_t;

    // Snoop data response beat
    typedef struct packed {
        logic [CD_DATA_W-1:0] data;
        logic                 last;                     // Final beat of burst
    } cd_chan_t;

    typedef enum logic [1:0] {
        IDLE,                                           // Waiting for a selection
        COLLECT,                                        // Gathering CRs
        CR_OUT,                                         // Presenting merged CR
        DRAIN                                           // Forwarding / dropping CD bursts
    } resp_state_e;

endpackage

`default_nettype wire

// File: resp_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface resp_ctrl_if import ccu_pkg::*; ();

    snoop_mask_t sel_mask;                              // Registered selection
    logic        collect_en;                            // High in COLLECT
    logic        cr_out_en;                             // High in CR_OUT
    logic        drain_en;                              // High in DRAIN
    logic        start;                                 // Selection accepted this cycle
    logic        cr_all_done;                           // All selected CRs captured
    logic        cr_sent;                               // Merged CR handshaken

    modport fsm (
        output sel_mask,
        output collect_en,
        output cr_out_en,
        output drain_en,
        output start,
        input  cr_all_done,
        input  cr_sent
    );

    modport data (
        input  sel_mask,
        input  collect_en,
        input  cr_out_en,
        input  drain_en,
        input  start,
        output cr_all_done,
        output cr_sent
    );

endinterface

`default_nettype wire

// File: snoop_resp_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_resp_fsm import ccu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    input  wire  snoop_mask_t sel_mask_i,               // Snoopers taking part
    input  wire         sel_valid_i,
    output logic        sel_ready_o,
    resp_ctrl_if.fsm    ctrl,
    input  wire  snoop_mask_t dt_mask_i,                // Snoopers that will send data
    output logic        cnt_load_o,                     // Load drain counter
    input  wire         cnt_zero_i                      // All bursts drained
);

    resp_state_e state_q;
    resp_state_e state_d;
    snoop_mask_t sel_mask_q;
    logic        sel_take;
    logic        data_pending;

    assign sel_ready_o  = (state_q == IDLE);
    assign sel_take     = sel_valid_i && sel_ready_o;
    assign data_pending = (dt_mask_i != '0);            // Merged DataTransfer flag

    assign ctrl.sel_mask   = sel_mask_q;
    assign ctrl.start      = sel_take;
    assign ctrl.collect_en = (state_q == COLLECT);
    assign ctrl.cr_out_en  = (state_q == CR_OUT);
    assign ctrl.drain_en   = (state_q == DRAIN);

    // Counter is loaded in the same cycle the merged CR leaves
    assign cnt_load_o = ctrl.cr_sent && data_pending;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (sel_take) begin
                    state_d = COLLECT;
                end
            end
            COLLECT: begin
                if (ctrl.cr_all_done) begin
                    state_d = CR_OUT;
                end
            end
            CR_OUT: begin
                if (ctrl.cr_sent) begin
                    state_d = data_pending ? DRAIN : IDLE;
                end
            end
            DRAIN: begin
                if (cnt_zero_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            sel_mask_q <= '0;
        end else begin
            state_q <= state_d;
            if (sel_take) begin
                sel_mask_q <= sel_mask_i;               // Held for the whole transaction
            end
        end
    end

endmodule

`default_nettype wire

// File: cd_drain_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cd_drain_counter import ccu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    input  wire         load_i,
    input  wire  snoop_mask_t load_mask_i,              // Data responders
    input  wire         dec_i,                          // One burst completed
    output logic        zero_o
);

    drain_cnt_t cnt_q;
    drain_cnt_t load_val;

    // Population count of the data responders
    always_comb begin
        load_val = '0;
        for (int i = 0; i < NUM_SNOOPERS; i++) begin
            load_val = load_val + drain_cnt_t'(load_mask_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= load_val;
        end else if (dec_i && (cnt_q != '0)) begin
            cnt_q <= cnt_q - drain_cnt_t'(1);
        end
    end

    assign zero_o = (cnt_q == '0);

endmodule

`default_nettype wire

// File: cr_merge.sv
`timescale 1ns/1ps
`default_nettype none

module cr_merge import ccu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    resp_ctrl_if.data   ctrl,
    input  wire  snoop_mask_t cr_valid_i,
    output snoop_mask_t cr_ready_o,
    input  wire  cr_chan_t [NUM_SNOOPERS-1:0] cr_chan_i,
    output logic        cr_valid_o,
    input  wire         cr_ready_i,
    output cr_chan_t    cr_chan_o,
    output snoop_mask_t dt_mask_o                       // Captured CRs with DataTransfer
);

    snoop_mask_t                 captured_q;
    snoop_mask_t                 cr_take;
    cr_chan_t [NUM_SNOOPERS-1:0] cr_q;

    // Ready only for selected snoopers still owing a CR
    assign cr_ready_o = ctrl.collect_en ? (ctrl.sel_mask & ~captured_q) : '0;
    assign cr_take    = cr_valid_i & cr_ready_o;

    // Counts captures of this cycle so CR_OUT follows the last one directly
    assign ctrl.cr_all_done = ctrl.collect_en && ((captured_q | cr_take) == ctrl.sel_mask);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            captured_q <= '0;
        end else if (ctrl.start) begin
            captured_q <= '0;                           // New transaction
        end else begin
            captured_q <= captured_q | cr_take;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int j = 0; j < NUM_SNOOPERS; j++) begin
            if (cr_take[j]) begin
                cr_q[j] <= cr_chan_i[j];
            end
        end
    end

    // Flags are single bits, so a struct-wide OR merges each one
    always_comb begin
        cr_chan_o = '0;
        dt_mask_o = '0;
        for (int j = 0; j < NUM_SNOOPERS; j++) begin
            if (captured_q[j]) begin
                cr_chan_o    = cr_chan_o | cr_q[j];
                dt_mask_o[j] = cr_q[j].data_transfer;
            end
        end
    end

    assign cr_valid_o   = ctrl.cr_out_en;
    assign ctrl.cr_sent = cr_valid_o && cr_ready_i;

endmodule

`default_nettype wire

// File: cd_route.sv
`timescale 1ns/1ps
`default_nettype none

module cd_route import ccu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    resp_ctrl_if.data   ctrl,
    input  wire  snoop_mask_t dt_mask_i,                // Expected data responders
    input  wire  snoop_mask_t cd_valid_i,
    output snoop_mask_t cd_ready_o,
    input  wire  cd_chan_t [NUM_SNOOPERS-1:0] cd_chan_i,
    output logic        cd_valid_o,
    input  wire         cd_ready_i,
    output cd_chan_t    cd_chan_o,
    output logic        burst_done_o                    // Last beat accepted
);

    snoop_mask_t done_q;
    snoop_mask_t pending;
    snoop_mask_t cand;
    snoop_mask_t first_oh;
    snoop_mask_t drop_req;
    snoop_mask_t drop_gnt;
    snoop_mask_t beat_take;
    snoop_mask_t last_take;
    snoop_idx_t  fr_q;
    snoop_idx_t  fr_lowest;
    snoop_idx_t  fr_sel;
    logic        fr_lock_q;
    logic        any_cand;
    logic        route_en;
    logic        fwd_last_take;

    assign pending = ctrl.drain_en ? (dt_mask_i & ~done_q) : '0;
    assign cand    = pending & cd_valid_i;

    // Lowest index wins
    always_comb begin
        fr_lowest = '0;
        for (int i = NUM_SNOOPERS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                fr_lowest = snoop_idx_t'(i);
            end
        end
    end

    assign any_cand = |cand;
    assign route_en = fr_lock_q || any_cand;            // First responder known
    assign fr_sel   = fr_lock_q ? fr_q : fr_lowest;

    always_comb begin
        first_oh = '0;
        if (route_en) begin
            first_oh[fr_sel] = 1'b1;
        end
    end

    // Forward path is purely combinational
    assign cd_valid_o    = |(cand & first_oh);
    assign cd_chan_o     = cd_chan_i[fr_sel];
    assign fwd_last_take = cd_valid_o && cd_ready_i && cd_chan_o.last;

    // One dropped stream per cycle, lowest index first
    assign drop_req = cand & ~first_oh;
    assign drop_gnt = drop_req & (~drop_req + snoop_mask_t'(1));

    // A dropped beat waits while the forwarded burst ends, one decrement per cycle
    always_comb begin
        cd_ready_o = first_oh & pending & {NUM_SNOOPERS{cd_ready_i}};
        if (!fwd_last_take) begin
            cd_ready_o = cd_ready_o | drop_gnt;
        end
    end

    assign beat_take = cd_valid_i & cd_ready_o;

    always_comb begin
        for (int j = 0; j < NUM_SNOOPERS; j++) begin
            last_take[j] = beat_take[j] && cd_chan_i[j].last;
        end
    end

    assign burst_done_o = |last_take;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q    <= '0;
            fr_q      <= '0;
            fr_lock_q <= 1'b0;
        end else if (ctrl.start) begin
            done_q    <= '0;
            fr_lock_q <= 1'b0;                          // Unlock for the next transaction
        end else begin
            done_q <= done_q | last_take;
            if (!fr_lock_q && any_cand) begin
                fr_q      <= fr_lowest;
                fr_lock_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: snoop_resp_top.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_resp_top import ccu_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    input  wire  snoop_mask_t oup_sel_i,
    input  wire         oup_sel_valid_i,
    output logic        oup_sel_ready_o,
    input  wire  snoop_mask_t cr_valids_i,
    output snoop_mask_t cr_readies_o,
    input  wire  cr_chan_t [NUM_SNOOPERS-1:0] cr_chans_i,
    input  wire  snoop_mask_t cd_valids_i,
    output snoop_mask_t cd_readies_o,
    input  wire  cd_chan_t [NUM_SNOOPERS-1:0] cd_chans_i,
    output logic        cr_valid_o,
    input  wire         cr_ready_i,
    output cr_chan_t    cr_chan_o,
    output logic        cd_valid_o,
    input  wire         cd_ready_i,
    output cd_chan_t    cd_chan_o
);

    snoop_mask_t dt_mask;                               // Snoopers owing a data burst
    logic        cnt_load;
    logic        cnt_zero;
    logic        burst_done;

    resp_ctrl_if ctrl_if ();

    snoop_resp_fsm i_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .sel_mask_i  (oup_sel_i),
        .sel_valid_i (oup_sel_valid_i),
        .sel_ready_o (oup_sel_ready_o),
        .ctrl        (ctrl_if.fsm),
        .dt_mask_i   (dt_mask),
        .cnt_load_o  (cnt_load),
        .cnt_zero_i  (cnt_zero)
    );

    cd_drain_counter i_drain_cnt (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (cnt_load),
        .load_mask_i (dt_mask),
        .dec_i       (burst_done),
        .zero_o      (cnt_zero)
    );

    cr_merge i_cr_merge (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ctrl       (ctrl_if.data),
        .cr_valid_i (cr_valids_i),
        .cr_ready_o (cr_readies_o),
        .cr_chan_i  (cr_chans_i),
        .cr_valid_o (cr_valid_o),
        .cr_ready_i (cr_ready_i),
        .cr_chan_o  (cr_chan_o),
        .dt_mask_o  (dt_mask)
    );

    cd_route i_cd_route (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctrl         (ctrl_if.data),
        .dt_mask_i    (dt_mask),
        .cd_valid_i   (cd_valids_i),
        .cd_ready_o   (cd_readies_o),
        .cd_chan_i    (cd_chans_i),
        .cd_valid_o   (cd_valid_o),
        .cd_ready_i   (cd_ready_i),
        .cd_chan_o    (cd_chan_o),
        .burst_done_o (burst_done)
    );

endmodule

`default_nettype wire

// File: tb_snoop_resp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snoop_resp import ccu_pkg::*; ();

    localparam int TIMEOUT = 200;                       // Cycles per wait loop

    logic                         clk = 1'b0;
    logic                         rst_n;
    snoop_mask_t                  oup_sel;
    logic                         oup_sel_valid;
    logic                         oup_sel_ready;
    snoop_mask_t                  cr_valids;
    snoop_mask_t                  cr_readies;
    cr_chan_t [NUM_SNOOPERS-1:0]  cr_chans;
    snoop_mask_t                  cd_valids;
    snoop_mask_t                  cd_readies;
    cd_chan_t [NUM_SNOOPERS-1:0]  cd_chans;
    logic                         cr_valid;
    logic                         cr_ready;
    cr_chan_t                     cr_chan;
    logic                         cd_valid;
    logic                         cd_ready;
    cd_chan_t                     cd_chan;

    cr_chan_t             t_cr    [NUM_SNOOPERS];      // CR each snooper answers with
    int                   t_beats [NUM_SNOOPERS];
    int                   t_delay [NUM_SNOOPERS];      // Cycles after the merged CR leaves
    logic [CD_DATA_W-1:0] t_base  [NUM_SNOOPERS];
    snoop_mask_t          cur_sel;
    cd_chan_t             exp_cd [$];
    int                   errors = 0;
    int                   timeouts = 0;

    snoop_resp_top dut_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .oup_sel_i       (oup_sel),
        .oup_sel_valid_i (oup_sel_valid),
        .oup_sel_ready_o (oup_sel_ready),
        .cr_valids_i     (cr_valids),
        .cr_readies_o    (cr_readies),
        .cr_chans_i      (cr_chans),
        .cd_valids_i     (cd_valids),
        .cd_readies_o    (cd_readies),
        .cd_chans_i      (cd_chans),
        .cr_valid_o      (cr_valid),
        .cr_ready_i      (cr_ready),
        .cr_chan_o       (cr_chan),
        .cd_valid_o      (cd_valid),
        .cd_ready_i      (cd_ready),
        .cd_chan_o       (cd_chan)
    );

    always #5 clk = ~clk;

    task automatic check_cr(input string name, input cr_chan_t got, input cr_chan_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cd(input string name, input cd_chan_t got, input cd_chan_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input snoop_mask_t got, input snoop_mask_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        timeouts++;
    endtask

    function automatic cr_chan_t make_cr(input logic wu, sh, pd, er, dt);
        cr_chan_t cr;
        cr.was_unique    = wu;
        cr.is_shared     = sh;
        cr.pass_dirty    = pd;
        cr.error         = er;
        cr.data_transfer = dt;
        return cr;
    endfunction

    function automatic logic [CD_DATA_W-1:0] beat_data(input int j, input int k);
        return t_base[j] + CD_DATA_W'(k);
    endfunction

    task automatic select_snoopers(input snoop_mask_t sel);
        int t;
        oup_sel       <= sel;
        oup_sel_valid <= 1'b1;
        for (t = 0; t < TIMEOUT; t++) begin
            @(posedge clk);
            if (oup_sel_valid && oup_sel_ready) break;
        end
        oup_sel_valid <= 1'b0;
        if (t == TIMEOUT) report_timeout("selection handshake");
    endtask

    task automatic send_cr(input int j);
        int t;
        cr_chans[j]  <= t_cr[j];
        cr_valids[j] <= 1'b1;
        for (t = 0; t < TIMEOUT; t++) begin
            @(posedge clk);
            if (cr_valids[j] && cr_readies[j]) break;
        end
        cr_valids[j] <= 1'b0;
        if (t == TIMEOUT) report_timeout("CR handshake of a snooper");
    endtask

    task automatic send_burst(input int j);
        int       t;
        int       k;
        cd_chan_t beat;
        for (t = 0; t < TIMEOUT; t++) begin             // Data follows the merged CR
            @(posedge clk);
            if (cr_valid && cr_ready) break;
        end
        if (t == TIMEOUT) begin
            report_timeout("merged CR before a data burst");
            return;
        end
        repeat (t_delay[j]) @(posedge clk);
        for (k = 0; k < t_beats[j]; k++) begin
            beat.data     = beat_data(j, k);
            beat.last     = (k == t_beats[j] - 1);
            cd_chans[j]  <= beat;
            cd_valids[j] <= 1'b1;
            for (t = 0; t < TIMEOUT; t++) begin
                @(posedge clk);
                if (cd_valids[j] && cd_readies[j]) break;
            end
            if (t == TIMEOUT) report_timeout("data beat handshake of a snooper");
        end
        cd_valids[j] <= 1'b0;
    endtask

    task automatic snooper(input int j);
        if (!cur_sel[j]) return;
        send_cr(j);
        if (t_cr[j].data_transfer) send_burst(j);
    endtask

    task automatic sink_cr(input cr_chan_t exp, input bit bp);
        int t;
        if (bp) cr_ready <= 1'b0;                       // Force at least one stall
        for (t = 0; t < TIMEOUT; t++) begin
            @(posedge clk);
            if (cr_valid) check_cr("cr_chan_o", cr_chan, exp);
            if (cr_valid && cr_ready) break;
            if (bp) cr_ready <= ($urandom % 2) != 0;
        end
        cr_ready <= 1'b1;
        if (t == TIMEOUT) report_timeout("merged CR output");
    endtask

    task automatic sink_cd(input bit bp);
        int t;
        int k;
        k = 0;
        if (bp) cd_ready <= 1'b0;
        for (t = 0; t < TIMEOUT && k < exp_cd.size(); t++) begin
            @(posedge clk);
            if (cd_valid && cd_ready) begin
                check_cd("cd_chan_o", cd_chan, exp_cd[k]);
                k++;
            end
            if (bp) cd_ready <= ($urandom % 2) != 0;
        end
        cd_ready <= 1'b1;
        if (k < exp_cd.size()) report_timeout("forwarded data beats");
    endtask

    // Runs until the DUT is back in IDLE
    task automatic watch_txn(input snoop_mask_t exp_dt);
        int t;
        int n_fwd;
        n_fwd = 0;
        for (t = 0; t < TIMEOUT; t++) begin
            @(posedge clk);
            if (oup_sel_ready) break;
            check_mask("cr_readies_o (unselected bits)", cr_readies & ~cur_sel, '0);
            check_mask("cd_readies_o (no data bits)", cd_readies & ~exp_dt, '0);
            if (cd_valid && n_fwd >= exp_cd.size()) begin
                $display("cd_valid_o rose with no expected data beat left to forward");
                errors++;
            end
            if (cd_valid && cd_ready) n_fwd++;
        end
        if (t == TIMEOUT) report_timeout("return to IDLE");
    endtask

    task automatic run_txn(input snoop_mask_t sel, input bit bp);
        cr_chan_t    exp_cr;
        snoop_mask_t exp_dt;
        cd_chan_t    beat;
        int          fr;
        int          j;
        int          k;
        exp_cr = '0;
        exp_dt = '0;
        fr     = -1;
        exp_cd.delete();
        for (j = 0; j < NUM_SNOOPERS; j++) begin
            t_base[j] = {$urandom, $urandom};
            if (sel[j]) begin
                exp_cr    = exp_cr | t_cr[j];
                exp_dt[j] = t_cr[j].data_transfer;
            end else begin
                cr_chans[j]  <= '1;                     // Stale CR outside the selection
                cr_valids[j] <= 1'b1;
            end
        end
        // Earliest valid wins with ties going to the lowest index
        for (j = 0; j < NUM_SNOOPERS; j++) begin
            if (exp_dt[j] && (fr < 0 || t_delay[j] < t_delay[fr])) fr = j;
        end
        if (fr >= 0) begin
            for (k = 0; k < t_beats[fr]; k++) begin
                beat.data = beat_data(fr, k);
                beat.last = (k == t_beats[fr] - 1);
                exp_cd.push_back(beat);
            end
        end
        cur_sel = sel;
        select_snoopers(sel);
        fork
            snooper(0);
            snooper(1);
            snooper(2);
            snooper(3);
            sink_cr(exp_cr, bp);
            sink_cd(bp);
            watch_txn(exp_dt);
        join
        cr_valids <= '0;
    endtask

    task automatic reset_values();
        check_flag("oup_sel_ready_o", oup_sel_ready, 1'b1);
        check_flag("cr_valid_o", cr_valid, 1'b0);
        check_flag("cd_valid_o", cd_valid, 1'b0);
        check_mask("cr_readies_o", cr_readies, '0);
        check_mask("cd_readies_o", cd_readies, '0);
    endtask

    task automatic single_no_data();
        t_cr[2] = make_cr(1, 1, 0, 0, 0);
        run_txn(4'b0100, 1'b0);
    endtask

    task automatic merge_flags();
        t_cr[0] = make_cr(1, 0, 0, 0, 0);
        t_cr[1] = make_cr(0, 1, 0, 0, 0);
        t_cr[3] = make_cr(0, 0, 1, 1, 0);
        run_txn(4'b1011, 1'b0);                         // Snooper 2 holds an all-ones CR
    endtask

    task automatic one_data_burst();
        t_cr[1]    = make_cr(0, 0, 1, 0, 1);
        t_beats[1] = 4;
        t_delay[1] = 1;
        run_txn(4'b0010, 1'b0);
    endtask

    task automatic two_data_bursts();
        t_cr[0]    = make_cr(0, 1, 0, 0, 0);
        t_cr[1]    = make_cr(1, 0, 0, 0, 1);
        t_beats[1] = 3;
        t_delay[1] = 4;                                 // Arrives mid-burst of snooper 3
        t_cr[3]    = make_cr(0, 1, 1, 0, 1);
        t_beats[3] = 6;
        t_delay[3] = 0;
        run_txn(4'b1011, 1'b0);
        t_cr[2] = make_cr(0, 1, 0, 0, 0);
        run_txn(4'b0100, 1'b0);
    endtask

    task automatic random_backpressure();
        t_cr[0]    = make_cr(0, 0, 0, 0, 1);
        t_beats[0] = 5;
        t_delay[0] = 2;
        t_cr[1]    = make_cr(0, 1, 0, 0, 0);
        t_cr[2]    = make_cr(1, 0, 0, 1, 1);
        t_beats[2] = 4;
        t_delay[2] = 0;
        t_cr[3]    = make_cr(0, 0, 1, 0, 0);
        run_txn(4'b1111, 1'b1);
    endtask

    initial begin
        void'($urandom(32'hb8d05c58));
        rst_n         <= 1'b0;
        oup_sel       <= '0;
        oup_sel_valid <= 1'b0;
        cr_valids     <= '0;
        cr_chans      <= '0;
        cd_valids     <= '0;
        cd_chans      <= '0;
        cr_ready      <= 1'b1;
        cd_ready      <= 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_values();
        single_no_data();
        merge_flags();
        one_data_burst();
        two_data_bursts();
        random_backpressure();
        $display("Run finished with %0d value errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
ccu_pkg.sv
resp_ctrl_if.sv
snoop_resp_fsm.sv
cd_drain_counter.sv
cr_merge.sv
cd_route.sv
snoop_resp_top.sv
tb_snoop_resp.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_snoop_resp -f sources.f
out=$(./obj_dir/Vtb_snoop_resp)
echo "$out"

if grep -qx "TEST OK" <<< "$out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
